// File: Makefile
# Verilator flow for the misc control block

VERILATOR ?= verilator
TOP       ?= misc_ctrl_tb
FLIST     ?= misc_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the run prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: boot_reset_seq.sv
// Core reset sequencer with bootloader done pulse and boot address window swap
`timescale 1ns/1ps

module boot_reset_seq (
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        bldr_done_i,
   input  logic [15:0] cpu_adr_i,
   output logic        core_rst_o,
   output logic [15:0] mem_adr_o
);

   localparam logic ST_WAIT = 1'b0;
   localparam logic ST_DONE = 1'b1;

   logic state;
   logic in_window;

   ////////////////////////////////////////////////////////////
   // Wait for the bootloader, then reset the core once
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state      <= ST_WAIT;
         core_rst_o <= 1'b1;
      end else begin
         case (state)
            ST_WAIT: begin
               core_rst_o <= 1'b0;
               if (bldr_done_i) begin
                  state      <= ST_DONE;
                  core_rst_o <= 1'b1;
               end
            end
            ST_DONE: begin
               // Only a power-on reset brings us back
               core_rst_o <= 1'b0;
            end
            default: begin
               state      <= ST_WAIT;
               core_rst_o <= 1'b0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Address window swap
   // The low 16K and the top 16K are the two windows with equal bits 15 and 14
   assign in_window = cpu_adr_i[15] == cpu_adr_i[14];

   always_comb begin
      if ((state == ST_WAIT) && in_window) begin
         mem_adr_o = cpu_adr_i ^ misc_ctrl_pkg::BOOT_SWAP_MASK;
      end else begin
         mem_adr_o = cpu_adr_i;
      end
   end

endmodule

// File: misc_ctrl.f
misc_ctrl_pkg.sv
misc_set_capture.sv
misc_reg_bank.sv
misc_pin_map.sv
boot_reset_seq.sv
status_readback.sv
misc_ctrl_top.sv
misc_ctrl_clkgen.sv
misc_ctrl_chk.sv
misc_ctrl_tb.sv

// File: misc_ctrl_chk.sv
// Bound assertions on the misc control top level for ack width, core reset pulse and known pins
`timescale 1ns/1ps

module misc_ctrl_chk (
   input logic        dsp_clk,
   input logic        por_rst,
   input logic        core_rst_i,
   input logic        rd_ack_i,
   input logic [21:0] ctrl_i
);

   int fail_cnt = 0;

   ////////////////////////////////////////////////////////////
   // A read answers with exactly one ack cycle
   ack_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rd_ack_i |=> !rd_ack_i)
      else begin
         fail_cnt++;
         $error("rd_ack_o high for two cycles");
      end

   // Bootloader reset is a single pulse
   core_rst_pulse: assert property (@(posedge dsp_clk) disable iff (por_rst)
      core_rst_i |=> !core_rst_i)
      else begin
         fail_cnt++;
         $error("core reset high for two cycles outside power-on reset");
      end

   pins_known: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !$isunknown(ctrl_i))
      else begin
         fail_cnt++;
         $error("control outputs unknown after power-on reset");
      end

endmodule

////////////////////////////////////////////////////////////
// Attach to every instance of the top level
bind misc_ctrl_top misc_ctrl_chk chk0 (
   .dsp_clk(dsp_clk), .por_rst(por_rst), .core_rst_i(core_rst), .rd_ack_i(rd_ack_o),
   .ctrl_i({clock_ready_o, clk_en_o, clk_sel_o, ser_enable_o, ser_prbsen_o, ser_loopen_o,
            ser_rx_en_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_reset_n_o,
            leds_o}));

// File: misc_ctrl_clkgen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module misc_ctrl_clkgen #(
   parameter int PERIOD     = 40,
   parameter int RST_CYCLES = 2,
   parameter int DLY        = 2
) (
   output logic dsp_clk_o,
   output logic por_rst_o
);

   initial begin
      dsp_clk_o = 1'b0;
      forever #(PERIOD / 2) dsp_clk_o = ~dsp_clk_o;
   end

   // Release reset just after the last reset edge
   initial begin
      por_rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge dsp_clk_o);
      #DLY;
      por_rst_o = 1'b0;
   end

endmodule

// File: misc_ctrl_pkg.sv
// Settings bus widths, register offsets, reset values, structs, control byte union, compat number
package misc_ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // Settings bus geometry
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int MISC_REGS  = 7;

   // Offsets inside the misc block
   localparam logic [2:0] REG_CLOCK   = 3'd0;
   localparam logic [2:0] REG_SERDES  = 3'd1;
   localparam logic [2:0] REG_ADC     = 3'd2;
   localparam logic [2:0] REG_LED_SW  = 3'd3;
   localparam logic [2:0] REG_PHY     = 3'd4;
   localparam logic [2:0] REG_BLDR    = 3'd5;
   localparam logic [2:0] REG_LED_SRC = 3'd6;

   // LEDs 1..4 belong to hardware out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'b0001_1110;

   // Bump when the register map changes
   localparam logic [15:0] COMPAT_MAJOR = 16'd9;
   localparam logic [15:0] COMPAT_MINOR = 16'd1;

   // Readback word indices
   localparam logic [3:0] RB_COMPAT = 4'd12;
   localparam logic [3:0] RB_STATUS = 4'd13;

   // Boot RAM and main RAM trade places until the bootloader is done
   localparam logic [15:0] BOOT_SWAP_MASK = 16'hC000;

   ////////////////////////////////////////////////////////////
   // Bus and register types
   typedef struct packed {
      logic                  stb;
      logic [2:0]            off;
      logic [SET_DATA_W-1:0] data;
   } set_wr_t;

   typedef struct packed {
      logic [2:0] spare;
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic [3:0] spare;
      logic       enable;
      logic       prbsen;
      logic       loopen;
      logic       rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic [3:0] spare;
      logic       oe_a;
      logic       on_a;
      logic       oe_b;
      logic       on_b;
   } adc_ctrl_t;

   // Same settings byte, read according to the register it landed in
   typedef union packed {
      logic [7:0]   raw;
      clock_ctrl_t  clk;
      serdes_ctrl_t ser;
      adc_ctrl_t    adc;
   } ctrl_byte_u;

   typedef struct packed {
      ctrl_byte_u clock_ctl;
      ctrl_byte_u serdes_ctl;
      ctrl_byte_u adc_ctl;
      logic [7:0] led_sw;
      logic [7:0] led_src;
      logic       phy_reset;
      logic       bldr_done;
      logic       spare;
   } misc_regs_t;

   typedef struct packed {
      logic clk_status;
      logic link_up;
      logic good_sync;
      logic button;
   } board_status_t;

endpackage

// File: misc_ctrl_tb.sv
// Testbench top that runs the test file against the misc control block and reports
`timescale 1ns/1ps

module misc_ctrl_tb;

   localparam int          DRV_DLY = 2;
   localparam int          MAX_OPS = 64;
   localparam int          BASE    = 0;
   localparam logic [31:0] SEED    = 32'h2450;
   localparam logic [7:0]  SW_ADDR  = 8'(BASE + int'(misc_ctrl_pkg::REG_LED_SW));
   localparam logic [7:0]  SRC_ADDR = 8'(BASE + int'(misc_ctrl_pkg::REG_LED_SRC));
   // Same offset as led_sw but one block up, so outside the misc block
   localparam logic [7:0]  ALIAS_ADDR = 8'(BASE + 8 + int'(misc_ctrl_pkg::REG_LED_SW));

   logic                         dsp_clk;
   logic                         por_rst;
   logic                         set_stb_i;
   logic [7:0]                   set_addr_i;
   logic [31:0]                  set_data_i;
   logic                         rd_stb_i;
   logic [3:0]                   rd_addr_i;
   logic [31:0]                  rd_data_o;
   logic                         rd_ack_o;
   logic                         run_rx0_i;
   logic                         run_rx1_i;
   logic                         run_tx_i;
   misc_ctrl_pkg::board_status_t board_i;
   logic [15:0]                  cpu_adr_i;
   logic [15:0]                  mem_adr_o;
   logic                         clock_ready_o;
   logic [1:0]                   clk_en_o;
   logic [1:0]                   clk_sel_o;
   logic                         ser_enable_o;
   logic                         ser_prbsen_o;
   logic                         ser_loopen_o;
   logic                         ser_rx_en_o;
   logic                         adc_oe_a_o;
   logic                         adc_on_a_o;
   logic                         adc_oe_b_o;
   logic                         adc_on_b_o;
   logic                         phy_reset_n_o;
   logic [7:0]                   leds_o;

   // Three words per operation: code, first argument, second argument
   logic [31:0] ops [0:3*MAX_OPS-1];
   logic [31:0] arg_a;
   logic [31:0] arg_b;
   logic [31:0] rng;
   logic [7:0]  led_hw;
   string       kind;
   int          idx;
   int          n_ops;
   int          cyc = 0;
   int          cyc_limit;
   int          mark;
   int          errors;
   int          err_before;
   int          n_tests;
   int          n_failed;

   misc_ctrl_clkgen #(.PERIOD(40), .RST_CYCLES(2), .DLY(DRV_DLY)) clkgen0 (
      .dsp_clk_o(dsp_clk), .por_rst_o(por_rst));

   misc_ctrl_top #(.MISC_BASE(BASE)) dut0 (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Each LED goes to hardware where its source bit is set, else to software
   function automatic logic [7:0] merge_leds(input logic [7:0] src, input logic [7:0] hw,
                                             input logic [7:0] sw);
      logic [7:0] m;
      for (int i = 0; i < 8; i++) begin
         m[i] = src[i] ? hw[i] : sw[i];
      end
      return m;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic step();
      @(posedge dsp_clk);
      #DRV_DLY;
   endtask

   task automatic settings_write(input logic [7:0] addr, input logic [31:0] data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      mark       = cyc;
      step();
      set_stb_i  = 1'b0;
   endtask

   // Pins settle three edges after the last write or input change
   task automatic wait_pins();
      while (cyc < mark + 3) begin
         step();
      end
   endtask

   task automatic check_pins(input logic [31:0] exp_ctl, input logic [7:0] exp_leds);
      compare_word("clock_ready_o,clk_en_o,clk_sel_o",
                   {27'b0, clock_ready_o, clk_en_o, clk_sel_o}, {24'b0, exp_ctl[15:8]});
      compare_word("ser_enable_o,ser_prbsen_o,ser_loopen_o,ser_rx_en_o",
                   {28'b0, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o},
                   {28'b0, exp_ctl[7:4]});
      compare_word("adc_oe_a_o,adc_on_a_o,adc_oe_b_o,adc_on_b_o",
                   {28'b0, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o},
                   {28'b0, exp_ctl[3:0]});
      compare_word("phy_reset_n_o", {31'b0, phy_reset_n_o}, {31'b0, exp_ctl[16]});
      compare_word("leds_o", {24'b0, leds_o}, {24'b0, exp_leds});
   endtask

   ////////////////////////////////////////////////////////////
   // Cycle counter and timeout
   always @(posedge dsp_clk) begin
      cyc <= cyc + 1;
      if (cyc_limit > 0 && cyc >= cyc_limit) begin
         $display("Timeout after %0d cycles, the test sequence did not finish", cyc);
         $display("TEST FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      set_stb_i  = 1'b0;
      set_addr_i = 8'h00;
      set_data_i = 32'h0;
      rd_stb_i   = 1'b0;
      rd_addr_i  = 4'h0;
      run_rx0_i  = 1'b0;
      run_rx1_i  = 1'b0;
      run_tx_i   = 1'b0;
      board_i    = '0;
      cpu_adr_i  = 16'h0;
      errors     = 0;
      n_tests    = 0;
      n_failed   = 0;
      mark       = 0;
      cyc_limit  = 0;
      rng        = SEED;
      $readmemh("misc_ctrl_tests.txt", ops);
      n_ops = 0;
      while (n_ops < MAX_OPS && ops[3*n_ops] !== 32'hF) begin
         n_ops++;
      end
      cyc_limit = 20 * n_ops + 100;
      wait (por_rst === 1'b1);
      wait (por_rst === 1'b0);
      step();
      for (idx = 0; idx < n_ops; idx++) begin
         arg_a      = ops[3*idx+1];
         arg_b      = ops[3*idx+2];
         err_before = errors;
         kind       = "";
         case (ops[3*idx])
            32'h0: settings_write(arg_a[7:0], arg_b);
            32'h1: begin
               kind      = "readback";
               rd_stb_i  = 1'b1;
               rd_addr_i = arg_a[3:0];
               step();
               rd_stb_i  = 1'b0;
               compare_word("rd_ack_o", {31'b0, rd_ack_o}, 32'h1);
               compare_word("rd_data_o", rd_data_o, arg_b);
               step();
               compare_word("rd_ack_o", {31'b0, rd_ack_o}, 32'h0);
            end
            32'h2: begin
               run_rx0_i = arg_a[2];
               run_rx1_i = arg_a[1];
               run_tx_i  = arg_a[0];
               board_i   = arg_b[3:0];
               mark      = cyc;
            end
            32'h3: begin
               kind      = "address map";
               cpu_adr_i = arg_a[15:0];
               step();
               compare_word("mem_adr_o", {16'h0, mem_adr_o}, arg_b);
            end
            32'h4: repeat (arg_a) step();
            32'h5: begin
               kind = "pin check";
               wait_pins();
               check_pins(arg_a, arg_b[7:0]);
            end
            32'h6: begin
               kind      = "led merge";
               // Hardware LED vector from the held status inputs
               led_hw    = 8'h00;
               led_hw[4] = run_tx_i;
               led_hw[3] = run_rx0_i | run_rx1_i;
               led_hw[2] = board_i.clk_status;
               led_hw[1] = board_i.link_up & board_i.good_sync;
               repeat (arg_a) begin
                  rng = xorshift(rng);
                  settings_write(SW_ADDR, {24'b0, rng[7:0]});
                  settings_write(SRC_ADDR, {24'b0, rng[15:8]});
                  settings_write(ALIAS_ADDR, {24'b0, ~rng[7:0]});
                  wait_pins();
                  compare_word("leds_o", {24'b0, leds_o},
                               {24'b0, merge_leds(rng[15:8], led_hw, rng[7:0])});
               end
            end
            default: begin
               $display("Operation %0d has an unknown code %h", idx, ops[3*idx]);
               errors++;
            end
         endcase
         if (kind != "") begin
            n_tests++;
            if (errors != err_before) begin
               n_failed++;
            end
            $display("Test %0d (op %0d) %0s: %0s", n_tests, idx, kind,
                     (errors == err_before) ? "ok" : "mismatch");
         end
      end
      errors = errors + dut0.chk0.fail_cnt;
      $display("Done: %0d tests, %0d failed, %0d assertion failures, %0d errors in all",
               n_tests, n_failed, dut0.chk0.fail_cnt, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: misc_ctrl_tests.txt
// Columns: op, arg_a, arg_b (hex). 0 write addr data, 1 read index expected,
// 2 status {rx0,rx1,tx} {clk,link,sync,button}, 3 cpu addr expected, 4 wait cycles,
// 5 pins {phy_n,clock byte,serdes,adc} leds, 6 led merge rounds, f end
2 7 f
4 4 0
5 10000 1e
3 1234 d234
3 8000 8000
3 c010 0010
3 4abc 4abc
0 0 1f
0 1 0a
0 2 05
0 4 1
5 1fa5 1e
0 7 ff
0 10 ff
0 ff ff
5 1fa5 1e
0 3 c3
5 1fa5 df
2 5 c
5 1fa5 dd
6 8 0
1 c 90001
1 d c00
2 0 1
1 d 2000
1 3 0
3 2000 e000
0 5 1
4 6 0
5 10000 0
3 1234 1234
3 c010 c010
3 0000 0000
f 0 0

// File: misc_ctrl_top.sv
// Top level of the misc control block, settings pipeline plus reset sequencer and readback
`timescale 1ns/1ps

module misc_ctrl_top #(
   parameter int MISC_BASE = 0
) (
   input  logic                                 dsp_clk,
   input  logic                                 por_rst,
   input  logic                                 set_stb_i,
   input  logic [misc_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [misc_ctrl_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                                 rd_stb_i,
   input  logic [3:0]                           rd_addr_i,
   output logic [31:0]                          rd_data_o,
   output logic                                 rd_ack_o,
   input  logic                                 run_rx0_i,
   input  logic                                 run_rx1_i,
   input  logic                                 run_tx_i,
   input  misc_ctrl_pkg::board_status_t         board_i,
   input  logic [15:0]                          cpu_adr_i,
   output logic [15:0]                          mem_adr_o,
   output logic                                 clock_ready_o,
   output logic [1:0]                           clk_en_o,
   output logic [1:0]                           clk_sel_o,
   output logic                                 ser_enable_o,
   output logic                                 ser_prbsen_o,
   output logic                                 ser_loopen_o,
   output logic                                 ser_rx_en_o,
   output logic                                 adc_oe_a_o,
   output logic                                 adc_on_a_o,
   output logic                                 adc_oe_b_o,
   output logic                                 adc_on_b_o,
   output logic                                 phy_reset_n_o,
   output logic [7:0]                           leds_o
);

   misc_ctrl_pkg::set_wr_t    wr;
   misc_ctrl_pkg::misc_regs_t regs;
   logic                      core_rst;

   ////////////////////////////////////////////////////////////
   // Settings pipeline
   misc_set_capture #(.MISC_BASE(MISC_BASE)) cap0 (
      .dsp_clk(dsp_clk), .por_rst(core_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .wr_o(wr));

   misc_reg_bank bank0 (
      .dsp_clk(dsp_clk), .por_rst(core_rst), .wr_i(wr), .regs_o(regs));

   misc_pin_map pins0 (
      .dsp_clk(dsp_clk), .por_rst(core_rst), .regs_i(regs),
      .run_rx0_i(run_rx0_i), .run_rx1_i(run_rx1_i), .run_tx_i(run_tx_i), .board_i(board_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   ////////////////////////////////////////////////////////////
   // Side blocks
   // Only the sequencer sees the raw power-on reset
   boot_reset_seq bootseq0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .bldr_done_i(regs.bldr_done),
      .cpu_adr_i(cpu_adr_i), .core_rst_o(core_rst), .mem_adr_o(mem_adr_o));

   status_readback rb0 (
      .dsp_clk(dsp_clk), .por_rst(core_rst), .rd_stb_i(rd_stb_i), .rd_addr_i(rd_addr_i),
      .board_i(board_i), .rd_data_o(rd_data_o), .rd_ack_o(rd_ack_o));

endmodule

// File: misc_pin_map.sv
// Stage 3 of the settings pipeline, registered control pins and LED source merge
`timescale 1ns/1ps

module misc_pin_map (
   input  logic                         dsp_clk,
   input  logic                         por_rst,
   input  misc_ctrl_pkg::misc_regs_t    regs_i,
   input  logic                         run_rx0_i,
   input  logic                         run_rx1_i,
   input  logic                         run_tx_i,
   input  misc_ctrl_pkg::board_status_t board_i,
   output logic                         clock_ready_o,
   output logic [1:0]                   clk_en_o,
   output logic [1:0]                   clk_sel_o,
   output logic                         ser_enable_o,
   output logic                         ser_prbsen_o,
   output logic                         ser_loopen_o,
   output logic                         ser_rx_en_o,
   output logic                         adc_oe_a_o,
   output logic                         adc_on_a_o,
   output logic                         adc_oe_b_o,
   output logic                         adc_on_b_o,
   output logic                         phy_reset_n_o,
   output logic [7:0]                   leds_o
);

   logic       run_rx_d1;
   logic [7:0] led_hw;
   logic [7:0] led_mix;

   // Hardware view of the LEDs
   assign led_hw = {3'b000, run_tx_i, run_rx_d1, board_i.clk_status,
                    board_i.link_up & board_i.good_sync, 1'b0};

   // A set led_src bit hands that LED to hardware
   assign led_mix = (regs_i.led_src & led_hw) | (~regs_i.led_src & regs_i.led_sw);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_rx_d1     <= 1'b0;
         clock_ready_o <= 1'b0;
         clk_en_o      <= 2'b00;
         clk_sel_o     <= 2'b00;
         ser_enable_o  <= 1'b0;
         ser_prbsen_o  <= 1'b0;
         ser_loopen_o  <= 1'b0;
         ser_rx_en_o   <= 1'b0;
         adc_oe_a_o    <= 1'b0;
         adc_on_a_o    <= 1'b0;
         adc_oe_b_o    <= 1'b0;
         adc_on_b_o    <= 1'b0;
         phy_reset_n_o <= 1'b1;
         leds_o        <= 8'h00;
      end else begin
         run_rx_d1     <= run_rx0_i | run_rx1_i;
         clock_ready_o <= regs_i.clock_ctl.clk.clock_ready;
         clk_en_o      <= regs_i.clock_ctl.clk.clk_en;
         clk_sel_o     <= regs_i.clock_ctl.clk.clk_sel;
         ser_enable_o  <= regs_i.serdes_ctl.ser.enable;
         ser_prbsen_o  <= regs_i.serdes_ctl.ser.prbsen;
         ser_loopen_o  <= regs_i.serdes_ctl.ser.loopen;
         ser_rx_en_o   <= regs_i.serdes_ctl.ser.rx_en;
         adc_oe_a_o    <= regs_i.adc_ctl.adc.oe_a;
         adc_on_a_o    <= regs_i.adc_ctl.adc.on_a;
         adc_oe_b_o    <= regs_i.adc_ctl.adc.oe_b;
         adc_on_b_o    <= regs_i.adc_ctl.adc.on_b;
         phy_reset_n_o <= ~regs_i.phy_reset;
         leds_o        <= led_mix;
      end
   end

endmodule

// File: misc_reg_bank.sv
// Stage 2 of the settings pipeline, the seven misc settings registers
`timescale 1ns/1ps

module misc_reg_bank (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  misc_ctrl_pkg::set_wr_t    wr_i,
   output misc_ctrl_pkg::misc_regs_t regs_o
);

   misc_ctrl_pkg::misc_regs_t regs_q;
   logic [7:0]                wr_byte;
   logic                      wr_bit;

   // Byte registers take the low byte, flag registers the low bit
   assign wr_byte = wr_i.data[7:0];
   assign wr_bit  = wr_i.data[0];

   ////////////////////////////////////////////////////////////
   // Register update
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         regs_q         <= '0;
         regs_q.led_src <= misc_ctrl_pkg::LED_SRC_RESET;
      end else if (wr_i.stb) begin
         case (wr_i.off)
            misc_ctrl_pkg::REG_CLOCK: begin
               regs_q.clock_ctl.raw <= wr_byte;
            end
            misc_ctrl_pkg::REG_SERDES: begin
               regs_q.serdes_ctl.raw <= wr_byte;
            end
            misc_ctrl_pkg::REG_ADC: begin
               regs_q.adc_ctl.raw <= wr_byte;
            end
            misc_ctrl_pkg::REG_LED_SW: begin
               regs_q.led_sw <= wr_byte;
            end
            misc_ctrl_pkg::REG_PHY: begin
               regs_q.phy_reset <= wr_bit;
            end
            misc_ctrl_pkg::REG_BLDR: begin
               // Set once by the bootloader, cleared again by the core reset it causes
               regs_q.bldr_done <= wr_bit;
            end
            misc_ctrl_pkg::REG_LED_SRC: begin
               regs_q.led_src <= wr_byte;
            end
            default: begin
               // Offset 7 is outside the block and never strobed
            end
         endcase
      end
   end

   assign regs_o = regs_q;

endmodule

// File: misc_set_capture.sv
// Stage 1 of the settings pipeline, write capture and misc block decode
`timescale 1ns/1ps

module misc_set_capture #(
   parameter int MISC_BASE = 0
) (
   input  logic                                 dsp_clk,
   input  logic                                 por_rst,
   input  logic                                 set_stb_i,
   input  logic [misc_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [misc_ctrl_pkg::SET_DATA_W-1:0] set_data_i,
   output misc_ctrl_pkg::set_wr_t               wr_o
);

   localparam int AW = misc_ctrl_pkg::SET_ADDR_W;
   localparam logic [AW-1:0] BASE_A  = AW'(MISC_BASE);
   localparam logic [AW-1:0] NREGS_A = AW'(misc_ctrl_pkg::MISC_REGS);

   logic [AW-1:0]                         rel_addr;
   logic                                  in_blk;
   logic                                  stb_q;
   logic [2:0]                            off_q;
   logic [misc_ctrl_pkg::SET_DATA_W-1:0]  data_q;

   // Below the base wraps to a large value, so one compare covers both ends
   assign rel_addr = set_addr_i - BASE_A;
   assign in_blk   = rel_addr < NREGS_A;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         stb_q <= 1'b0;
      end else begin
         stb_q <= set_stb_i & in_blk;
      end
   end

   // Offset and data just ride along with the strobe
   always_ff @(posedge dsp_clk) begin
      off_q  <= rel_addr[2:0];
      data_q <= set_data_i;
   end

   assign wr_o = '{stb: stb_q, off: off_q, data: data_q};

endmodule

// File: status_readback.sv
// Registered readback of the compatibility number and board status word
`timescale 1ns/1ps

module status_readback (
   input  logic                         dsp_clk,
   input  logic                         por_rst,
   input  logic                         rd_stb_i,
   input  logic [3:0]                   rd_addr_i,
   input  misc_ctrl_pkg::board_status_t board_i,
   output logic [31:0]                  rd_data_o,
   output logic                         rd_ack_o
);

   logic [31:0] compat_word;
   logic [31:0] status_word;
   logic [31:0] rd_word;

   assign compat_word = {misc_ctrl_pkg::COMPAT_MAJOR, misc_ctrl_pkg::COMPAT_MINOR};

   // Button at 13, clock status at 11, link at 10
   assign status_word = {18'b0, board_i.button, 1'b0, board_i.clk_status,
                         board_i.link_up, 10'b0};

   always_comb begin
      case (rd_addr_i)
         misc_ctrl_pkg::RB_COMPAT: rd_word = compat_word;
         misc_ctrl_pkg::RB_STATUS: rd_word = status_word;
         default:                  rd_word = 32'h0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rd_ack_o <= 1'b0;
      end else begin
         rd_ack_o <= rd_stb_i;
      end
   end

   // Data holds between reads
   always_ff @(posedge dsp_clk) begin
      if (rd_stb_i) begin
         rd_data_o <= rd_word;
      end
   end

endmodule
